// ==== common/asg_pkg.sv ====
//////////////////////////////////////////////////
// shared widths and encodings of the generator
// register select sits in bus_addr[3:0]
// slice of a wide register sits in bus_addr[5:4]
// bus_addr top bit set means table access
//////////////////////////////////////////////////

`default_nettype none

package asg_pkg;

  //////////////////////////////////////////////////
  // widths
  //////////////////////////////////////////////////

  localparam int unsigned asg_dwo = 14;  // sample and bus data width
  localparam int unsigned asg_cwm = 10;  // pointer integer bits, 1024 entries
  localparam int unsigned asg_cwf = 16;  // pointer fraction bits
  localparam int unsigned asg_nw  = 16;  // cycle and repetition counters
  localparam int unsigned asg_lw  = 32;  // delay between repetitions

  //////////////////////////////////////////////////
  // register map
  //////////////////////////////////////////////////

  typedef enum logic [3:0] {
    REG_CTL    = 4'd0,  // bit 0 restarts the sequencer
    REG_SIZE   = 4'd1,  // table size, fixed point
    REG_STEP   = 4'd2,  // pointer step, fixed point
    REG_OFFS   = 4'd3,  // start offset, fixed point
    REG_NCYC   = 4'd4,  // passes per run
    REG_RNUM   = 4'd5,  // extra runs after the first
    REG_RDLY   = 4'd6,  // idle cycles between runs
    REG_WRAP   = 4'd7,  // bit 0 keeps the wrap remainder
    REG_STATUS = 4'd8   // sequencer state, read only
  } reg_addr_t;

  // playback states
  typedef enum logic [1:0] {
    SEQ_IDLE = 2'd0,  // waiting for trigger
    SEQ_RUN  = 2'd1,  // reading table
    SEQ_GAP  = 2'd2   // delay between repetitions
  } seq_state_t;

endpackage

`default_nettype wire

// ==== design/asg_regs.sv ====
//////////////////////////////////////////////////
// bus decode into config registers and table port
// wide registers written in DWO bit slices
// needs CWM of at least 6 for the slice field
// read data one cycle late, held until next read
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module asg_regs import asg_pkg::*; #(
  parameter int unsigned DWO = asg_dwo,
  parameter int unsigned CWM = asg_cwm,
  parameter int unsigned CWF = asg_cwf
)(
  input  wire                  clk,
  input  wire                  rstn,
  // cpu bus
  input  wire                  bus_ena,
  input  wire                  bus_wen,
  input  wire        [CWM:0]   bus_addr,   // top bit selects table
  input  wire        [DWO-1:0] bus_wdata,
  output logic       [DWO-1:0] bus_rdata,
  // table cpu port
  output logic                 tbl_ena,
  output logic                 tbl_wen,
  output logic     [CWM-1:0]   tbl_addr,
  output logic     [DWO-1:0]   tbl_wdata,
  input  wire        [DWO-1:0] tbl_rdata,
  // sequencer config
  input  wire seq_state_t      seq_state,
  output logic [CWM+CWF-1:0]   cfg_size,
  output logic [CWM+CWF-1:0]   cfg_step,
  output logic [CWM+CWF-1:0]   cfg_offs,
  output logic [asg_nw-1:0]    cfg_ncyc,
  output logic [asg_nw-1:0]    cfg_rnum,
  output logic [asg_lw-1:0]    cfg_rdly,
  output logic                 cfg_wrap,
  output logic                 ctl_rst     // one cycle pulse
);

  localparam int unsigned PW = CWM + CWF;
  localparam int unsigned SW = 3 * DWO;  // widest register in slices

  logic           reg_wr;     // register write this cycle
  logic           reg_rd;     // register read this cycle
  reg_addr_t      reg_sel;
  logic [1:0]     slc;        // slice index
  logic [DWO-1:0] reg_rdata;  // registered readback
  logic           rd_tbl;     // last read went to table

  // replace one slice of a register value
  function automatic logic [SW-1:0] slice_wr(input logic [SW-1:0] old,
                                             input logic [1:0] sel,
                                             input logic [DWO-1:0] wd);
    logic [SW-1:0] tmp;
    tmp = old;
    case (sel)
      2'd0:    tmp[0 +: DWO] = wd;
      2'd1:    tmp[DWO +: DWO] = wd;
      default: tmp[2*DWO +: DWO] = wd;
    endcase
    return tmp;
  endfunction

  // pick one slice for readback
  function automatic logic [DWO-1:0] slice_rd(input logic [SW-1:0] val,
                                              input logic [1:0] sel);
    logic [SW-1:0] tmp;
    tmp = val >> (sel * DWO);
    return tmp[DWO-1:0];
  endfunction

  //////////////////////////////////////////////////
  // decode
  //////////////////////////////////////////////////

  assign reg_wr  = bus_ena && !bus_addr[CWM] && bus_wen;
  assign reg_rd  = bus_ena && !bus_addr[CWM] && !bus_wen;
  assign reg_sel = reg_addr_t'(bus_addr[3:0]);
  assign slc     = bus_addr[5:4];

  assign tbl_ena   = bus_ena && bus_addr[CWM];  // table window
  assign tbl_wen   = bus_wen;
  assign tbl_addr  = bus_addr[CWM-1:0];
  assign tbl_wdata = bus_wdata;

  //////////////////////////////////////////////////
  // config registers
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstn) begin
      cfg_size <= '0;
      cfg_step <= '0;
      cfg_offs <= '0;
      cfg_ncyc <= '0;
      cfg_rnum <= '0;
      cfg_rdly <= '0;
      cfg_wrap <= 1'b0;
    end else if (reg_wr) begin
      case (reg_sel)
        REG_SIZE: cfg_size <= PW'(slice_wr(SW'(cfg_size), slc, bus_wdata));
        REG_STEP: cfg_step <= PW'(slice_wr(SW'(cfg_step), slc, bus_wdata));
        REG_OFFS: cfg_offs <= PW'(slice_wr(SW'(cfg_offs), slc, bus_wdata));
        REG_NCYC: cfg_ncyc <= asg_nw'(slice_wr(SW'(cfg_ncyc), slc, bus_wdata));
        REG_RNUM: cfg_rnum <= asg_nw'(slice_wr(SW'(cfg_rnum), slc, bus_wdata));
        REG_RDLY: cfg_rdly <= asg_lw'(slice_wr(SW'(cfg_rdly), slc, bus_wdata));
        REG_WRAP: cfg_wrap <= bus_wdata[0];
        default:  ;  // ctl and status hold nothing
      endcase
    end
  end

  // restart pulse
  always_ff @(posedge clk) begin
    if (!rstn) ctl_rst <= 1'b0;
    else       ctl_rst <= reg_wr && (reg_sel == REG_CTL) && bus_wdata[0];
  end

  //////////////////////////////////////////////////
  // readback
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstn)                   rd_tbl <= 1'b0;
    else if (bus_ena && !bus_wen) rd_tbl <= bus_addr[CWM];  // source of last read
  end

  always_ff @(posedge clk) begin
    if (reg_rd) begin
      case (reg_sel)
        REG_SIZE:   reg_rdata <= slice_rd(SW'(cfg_size), slc);
        REG_STEP:   reg_rdata <= slice_rd(SW'(cfg_step), slc);
        REG_OFFS:   reg_rdata <= slice_rd(SW'(cfg_offs), slc);
        REG_NCYC:   reg_rdata <= slice_rd(SW'(cfg_ncyc), slc);
        REG_RNUM:   reg_rdata <= slice_rd(SW'(cfg_rnum), slc);
        REG_RDLY:   reg_rdata <= slice_rd(SW'(cfg_rdly), slc);
        REG_WRAP:   reg_rdata <= DWO'(cfg_wrap);
        REG_STATUS: reg_rdata <= DWO'(seq_state);
        default:    reg_rdata <= '0;  // ctl reads zero
      endcase
    end
  end

  assign bus_rdata = rd_tbl ? tbl_rdata : reg_rdata;

endmodule

`default_nettype wire

// ==== asg/asg_table.sv ====
//////////////////////////////////////////////////
// sample memory of 2**CWM signed entries
// cpu port reads back with one cycle latency
// stream port returns data two cycles after rd_en
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module asg_table import asg_pkg::*; #(
  parameter int unsigned DWO = asg_dwo,
  parameter int unsigned CWM = asg_cwm
)(
  input  wire                   clk,
  // cpu port
  input  wire                   tbl_ena,
  input  wire                   tbl_wen,
  input  wire         [CWM-1:0] tbl_addr,
  input  wire         [DWO-1:0] tbl_wdata,
  output logic        [DWO-1:0] tbl_rdata,
  // stream port
  input  wire                   rd_en,
  input  wire         [CWM-1:0] rd_addr,
  output logic signed [DWO-1:0] rd_dat,
  output logic                  rd_vld
);

  logic signed [DWO-1:0] mem [0:2**CWM-1];
  logic        [CWM-1:0] rd_addr_q;  // stage one address
  logic                  rd_en_q;    // stage one valid

  // cpu write
  always_ff @(posedge clk) begin
    if (tbl_ena && tbl_wen) mem[tbl_addr] <= tbl_wdata;
  end

  // cpu readback
  always_ff @(posedge clk) begin
    if (tbl_ena && !tbl_wen) tbl_rdata <= mem[tbl_addr];
  end

  // stream read, address then data
  always_ff @(posedge clk) begin
    rd_addr_q <= rd_addr;
    rd_en_q   <= rd_en;
    rd_dat    <= mem[rd_addr_q];
    rd_vld    <= rd_en_q;  // follows data stage
  end

endmodule

`default_nettype wire

// ==== asg/asg_sequencer.sv ====
//////////////////////////////////////////////////
// playback FSM with fixed point read pointer
// one table read per cycle while adv is high
// cfg_ncyc of zero behaves as one pass
// cfg_rdly of zero skips the gap state
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module asg_sequencer import asg_pkg::*; #(
  parameter int unsigned CWM = asg_cwm,
  parameter int unsigned CWF = asg_cwf
)(
  input  wire                 clk,
  input  wire                 rstn,
  // trigger
  input  wire                 trg_in,
  output logic                trg_out,   // accepted trigger echo
  // flow control from output stage
  input  wire                 adv,
  // config
  input  wire [CWM+CWF-1:0]   cfg_size,
  input  wire [CWM+CWF-1:0]   cfg_step,
  input  wire [CWM+CWF-1:0]   cfg_offs,
  input  wire [asg_nw-1:0]    cfg_ncyc,
  input  wire [asg_nw-1:0]    cfg_rnum,
  input  wire [asg_lw-1:0]    cfg_rdly,
  input  wire                 cfg_wrap,
  input  wire                 ctl_rst,
  // table read
  output logic                rd_en,
  output logic [CWM-1:0]      rd_addr,
  output seq_state_t          seq_state
);

  localparam int unsigned PW = CWM + CWF;

  seq_state_t         state;
  logic [PW-1:0]      pnt;       // read pointer
  logic [PW:0]        npnt;      // pointer plus step
  logic [PW+1:0]      npnt_sub;  // npnt minus size minus one
  logic               pass_end;  // npnt beyond table end
  logic               last_cyc;
  logic [asg_nw-1:0]  cyc_cnt;   // passes left in this run
  logic [asg_nw-1:0]  rep_cnt;   // runs left after this one
  logic [asg_lw-1:0]  dly_cnt;   // gap cycles left

  //////////////////////////////////////////////////
  // pointer arithmetic
  //////////////////////////////////////////////////

  assign npnt     = {1'b0, pnt} + {1'b0, cfg_step};
  assign npnt_sub = {1'b0, npnt} - {2'b00, cfg_size} - 1'b1;
  assign pass_end = !npnt_sub[PW+1];        // non negative means past size
  assign last_cyc = (cyc_cnt <= asg_nw'(1));

  assign trg_out   = (state == SEQ_IDLE) && trg_in && !ctl_rst;
  assign rd_en     = (state == SEQ_RUN) && adv;
  assign rd_addr   = pnt[CWF +: CWM];       // integer part
  assign seq_state = state;

  //////////////////////////////////////////////////
  // state machine
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstn) begin
      state   <= SEQ_IDLE;
      pnt     <= '0;
      cyc_cnt <= '0;
      rep_cnt <= '0;
      dly_cnt <= '0;
    end else if (ctl_rst) begin
      state <= SEQ_IDLE;  // abort from anywhere
    end else begin
      case (state)
        SEQ_IDLE: begin
          if (trg_in) begin
            pnt     <= cfg_offs;
            cyc_cnt <= cfg_ncyc;
            rep_cnt <= cfg_rnum;
            state   <= SEQ_RUN;
          end
        end
        SEQ_RUN: begin
          if (adv) begin
            if (!pass_end) begin
              pnt <= npnt[PW-1:0];  // plain advance
            end else if (!last_cyc) begin
              // next pass of the same run
              pnt     <= cfg_wrap ? npnt_sub[PW-1:0] : cfg_offs;
              cyc_cnt <= cyc_cnt - 1'b1;
            end else if (rep_cnt != '0) begin
              // next run, restart from offset
              rep_cnt <= rep_cnt - 1'b1;
              pnt     <= cfg_offs;
              cyc_cnt <= cfg_ncyc;
              if (cfg_rdly != '0) begin
                dly_cnt <= cfg_rdly;
                state   <= SEQ_GAP;
              end
            end else begin
              state <= SEQ_IDLE;    // all runs done
            end
          end
        end
        SEQ_GAP: begin
          if (dly_cnt <= asg_lw'(1)) state <= SEQ_RUN;
          else                       dly_cnt <= dly_cnt - 1'b1;
        end
        default: state <= SEQ_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== design/dac_credit_out.sv ====
//////////////////////////////////////////////////
// output FIFO with credit flow toward the DAC
// FIFO holds CREDITS plus 2 samples
// adv reserves room for reads still in the table
// sink must not return more credits than it took
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module dac_credit_out import asg_pkg::*; #(
  parameter int unsigned DWO     = asg_dwo,
  parameter int unsigned CREDITS = 4
)(
  input  wire                   clk,
  input  wire                   rstn,
  // from table stream port
  input  wire signed  [DWO-1:0] rd_dat,
  input  wire                   rd_vld,
  output logic                  adv,        // sequencer may read
  // DAC side
  output logic signed [DWO-1:0] sto_dat,
  output logic                  sto_vld,
  input  wire                   sto_credit  // one credit back
);

  localparam int unsigned DEPTH = CREDITS + 2;
  localparam int unsigned PTRW  = $clog2(DEPTH);
  localparam int unsigned CNTW  = $clog2(DEPTH + 1);
  localparam int unsigned CRDW  = $clog2(CREDITS + 1);

  logic signed [DWO-1:0] fifo [0:DEPTH-1];
  logic [PTRW-1:0] wr_ptr;
  logic [PTRW-1:0] rd_ptr;
  logic [CNTW-1:0] cnt;      // stored samples
  logic [CNTW-1:0] free;
  logic [1:0]      adv_q;    // adv history, one per pipe stage
  logic [1:0]      rsv_cnt;  // slots reserved for reads in flight
  logic [CRDW-1:0] crd_cnt;  // credits held

  //////////////////////////////////////////////////
  // FIFO
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rd_vld) fifo[wr_ptr] <= rd_dat;
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      cnt    <= '0;
    end else begin
      if (rd_vld) wr_ptr <= (wr_ptr == PTRW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (sto_vld) rd_ptr <= (rd_ptr == PTRW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      cnt <= cnt + CNTW'(rd_vld) - CNTW'(sto_vld);
    end
  end

  //////////////////////////////////////////////////
  // reservation and credits
  //////////////////////////////////////////////////

  // each adv cycle holds a slot until its data could land
  always_ff @(posedge clk) begin
    if (!rstn) begin
      adv_q   <= '0;
      rsv_cnt <= '0;
      crd_cnt <= CRDW'(CREDITS);
    end else begin
      adv_q   <= {adv_q[0], adv};
      rsv_cnt <= rsv_cnt + 2'(adv) - 2'(adv_q[1]);
      crd_cnt <= crd_cnt - CRDW'(sto_vld) + CRDW'(sto_credit);
    end
  end

  assign free    = CNTW'(DEPTH) - cnt;
  assign adv     = (free > CNTW'(rsv_cnt));
  assign sto_vld = (crd_cnt != '0) && (cnt != '0);
  assign sto_dat = fifo[rd_ptr];  // head of FIFO

endmodule

`default_nettype wire

// ==== design/asg_top.sv ====
//////////////////////////////////////////////////
// single channel waveform generator top
// bus_addr top bit selects the sample table
// sto_dat only meaningful while sto_vld is high
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module asg_top import asg_pkg::*; #(
  parameter int unsigned DWO     = asg_dwo,
  parameter int unsigned CWM     = asg_cwm,
  parameter int unsigned CWF     = asg_cwf,
  parameter int unsigned CREDITS = 4
)(
  input  wire                   clk,
  input  wire                   rstn,
  // cpu bus
  input  wire                   bus_ena,
  input  wire                   bus_wen,
  input  wire         [CWM:0]   bus_addr,
  input  wire         [DWO-1:0] bus_wdata,
  output logic        [DWO-1:0] bus_rdata,
  // trigger
  input  wire                   trg_in,
  output logic                  trg_out,
  // DAC stream
  output logic signed [DWO-1:0] sto_dat,
  output logic                  sto_vld,
  input  wire                   sto_credit
);

  // register block to table
  logic                  tbl_ena;
  logic                  tbl_wen;
  logic [CWM-1:0]        tbl_addr;
  logic [DWO-1:0]        tbl_wdata;
  logic [DWO-1:0]        tbl_rdata;
  // register block to sequencer
  logic [CWM+CWF-1:0]    cfg_size;
  logic [CWM+CWF-1:0]    cfg_step;
  logic [CWM+CWF-1:0]    cfg_offs;
  logic [asg_nw-1:0]     cfg_ncyc;
  logic [asg_nw-1:0]     cfg_rnum;
  logic [asg_lw-1:0]     cfg_rdly;
  logic                  cfg_wrap;
  logic                  ctl_rst;
  seq_state_t            seq_state;
  // stream path
  logic                  rd_en;
  logic [CWM-1:0]        rd_addr;
  logic signed [DWO-1:0] rd_dat;
  logic                  rd_vld;
  logic                  adv;

  //////////////////////////////////////////////////
  // input side
  //////////////////////////////////////////////////

  asg_regs #(.DWO(DWO), .CWM(CWM), .CWF(CWF)) regs0 (
    .clk, .rstn,
    .bus_ena, .bus_wen, .bus_addr, .bus_wdata, .bus_rdata,
    .tbl_ena, .tbl_wen, .tbl_addr, .tbl_wdata, .tbl_rdata,
    .seq_state,
    .cfg_size, .cfg_step, .cfg_offs, .cfg_ncyc, .cfg_rnum, .cfg_rdly, .cfg_wrap,
    .ctl_rst
  );

  //////////////////////////////////////////////////
  // table and sequencer
  //////////////////////////////////////////////////

  asg_table #(.DWO(DWO), .CWM(CWM)) table0 (
    .clk,
    .tbl_ena, .tbl_wen, .tbl_addr, .tbl_wdata, .tbl_rdata,
    .rd_en, .rd_addr, .rd_dat, .rd_vld
  );

  asg_sequencer #(.CWM(CWM), .CWF(CWF)) seq0 (
    .clk, .rstn,
    .trg_in, .trg_out, .adv,
    .cfg_size, .cfg_step, .cfg_offs, .cfg_ncyc, .cfg_rnum, .cfg_rdly, .cfg_wrap,
    .ctl_rst,
    .rd_en, .rd_addr, .seq_state
  );

  //////////////////////////////////////////////////
  // output side
  //////////////////////////////////////////////////

  dac_credit_out #(.DWO(DWO), .CREDITS(CREDITS)) out0 (
    .clk, .rstn,
    .rd_dat, .rd_vld, .adv,
    .sto_dat, .sto_vld, .sto_credit
  );

endmodule

`default_nettype wire

// ==== verification/asg_tb.sv ====
//////////////////////////////////////////////////
// testbench for the waveform generator top
// table content and credit gaps from xorshift
// expected samples from a pointer model of its own
// the run is bounded by a cycle budget per test
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module asg_tb import asg_pkg::*; ();

  localparam int          CREDITS   = 4;
  localparam int          DRAIN_CYC = CREDITS + 6;  // FIFO depth, table pipe and credit loop
  localparam logic [31:0] SEED      = 32'hd6a88754;

  // DUT side
  logic                      clk = 1'b0;
  logic                      rstn;
  logic                      bus_ena;
  logic                      bus_wen;
  logic [asg_cwm:0]          bus_addr;
  logic [asg_dwo-1:0]        bus_wdata;
  wire  [asg_dwo-1:0]        bus_rdata;
  logic                      trg_in;
  wire                       trg_out;
  wire  signed [asg_dwo-1:0] sto_dat;
  wire                       sto_vld;
  logic                      sto_credit = 1'b0;

  // model and bookkeeping
  logic signed [asg_dwo-1:0] tbl_ref [0:(1<<asg_cwm)-1];  // copy of the table
  logic signed [asg_dwo-1:0] exp_q [$];                   // samples still due
  logic signed [asg_dwo-1:0] exp_v;
  logic [31:0] rng_stim = SEED;
  logic [31:0] rng_crd  = SEED;
  bit          crd_random = 1'b0;  // credits back at random
  int err_cnt  = 0;
  int err_base = 0;
  int fail_cnt = 0;
  int tnum     = 1;
  int rx_cnt   = 0;   // samples seen on sto_vld
  int trg_cnt  = 0;   // trg_out pulses
  int gap_cnt  = 0;   // completed gaps
  int gap_len  = 0;
  int idle_len = 0;   // cycles since last sample
  int consumed = 0;
  int returned = 0;
  int cyc_cnt  = 0;
  int budget   = 20000;  // table load and readback
  // testbench copy of the current config
  longint c_size;
  longint c_step;
  longint c_offs;
  int     c_ncyc;
  int     c_rnum;
  int     c_rdly;
  bit     c_wrap;

  asg_top #(.CREDITS(CREDITS)) dut0 (
    .clk        (clk),
    .rstn       (rstn),
    .bus_ena    (bus_ena),
    .bus_wen    (bus_wen),
    .bus_addr   (bus_addr),
    .bus_wdata  (bus_wdata),
    .bus_rdata  (bus_rdata),
    .trg_in     (trg_in),
    .trg_out    (trg_out),
    .sto_dat    (sto_dat),
    .sto_vld    (sto_vld),
    .sto_credit (sto_credit)
  );

  always #10 clk = ~clk;  // 20 ns period

  //////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // register address with slice index
  function automatic logic [asg_cwm:0] reg_addr(input reg_addr_t ra, input logic [1:0] slc);
    return {1'b0, asg_cwm'({slc, ra})};
  endfunction

  // pointer walk that queues the expected samples and returns their count
  function automatic int build_expected(input longint size, input longint step,
                                        input longint offs, input int ncyc,
                                        input int rnum, input bit wrap);
    longint             p;
    longint             np;
    int                 cyc;
    int                 n;
    bit                 done;
    logic [asg_cwm-1:0] idx;
    n = 0;
    for (int r = 0; r <= rnum; r++) begin
      p    = offs;  // each run starts at the offset
      cyc  = ncyc;
      done = 1'b0;
      while (!done) begin
        idx = p[asg_cwf +: asg_cwm];
        exp_q.push_back(tbl_ref[idx]);
        n++;
        np = p + step;
        if (np > size) begin  // pass over
          cyc--;
          if (cyc <= 0) done = 1'b1;
          else          p = wrap ? np - size - 1 : offs;
        end else begin
          p = np;
        end
      end
    end
    return n;
  endfunction

  task automatic bus_write(input logic [asg_cwm:0] addr, input logic [asg_dwo-1:0] data);
    @(posedge clk);
    bus_ena   <= 1'b1;
    bus_wen   <= 1'b1;
    bus_addr  <= addr;
    bus_wdata <= data;
    @(posedge clk);
    bus_ena   <= 1'b0;
    bus_wen   <= 1'b0;
  endtask

  task automatic bus_read(input logic [asg_cwm:0] addr, output logic [asg_dwo-1:0] data);
    @(posedge clk);
    bus_ena  <= 1'b1;
    bus_wen  <= 1'b0;
    bus_addr <= addr;
    @(posedge clk);
    bus_ena  <= 1'b0;
    @(posedge clk);
    data = bus_rdata;  // held since the read edge
  endtask

  // wide register written as three slices
  task automatic reg_write(input reg_addr_t ra, input logic [3*asg_dwo-1:0] val);
    for (int s = 0; s < 3; s++) bus_write(reg_addr(ra, 2'(s)), val[s*asg_dwo +: asg_dwo]);
  endtask

  task automatic read_status(output seq_state_t st);
    logic [asg_dwo-1:0] d;
    bus_read(reg_addr(REG_STATUS, 2'd0), d);
    st = seq_state_t'(d[1:0]);
  endtask

  task automatic configure(input longint size, input longint step, input longint offs,
                           input int ncyc, input int rnum, input int rdly, input bit wrap);
    c_size = size;
    c_step = step;
    c_offs = offs;
    c_ncyc = ncyc;
    c_rnum = rnum;
    c_rdly = rdly;
    c_wrap = wrap;
    reg_write(REG_SIZE, 42'(size));
    reg_write(REG_STEP, 42'(step));
    reg_write(REG_OFFS, 42'(offs));
    reg_write(REG_NCYC, 42'(ncyc));
    reg_write(REG_RNUM, 42'(rnum));
    reg_write(REG_RDLY, 42'(rdly));
    bus_write(reg_addr(REG_WRAP, 2'd0), asg_dwo'(wrap));
  endtask

  // expected list for one trigger plus its share of the watchdog budget
  task automatic queue_expected(output int n);
    n = build_expected(c_size, c_step, c_offs, c_ncyc, c_rnum, c_wrap);
    budget += (n + c_rnum * c_rdly) * 8 + 2000;
  endtask

  task automatic fire_trigger();
    @(posedge clk);
    trg_in <= 1'b1;
    @(posedge clk);
    trg_in <= 1'b0;
  endtask

  // wait for every sample and an idle sequencer, then watch for strays
  task automatic wait_done();
    seq_state_t st;
    while (exp_q.size() != 0) @(posedge clk);
    do read_status(st); while (st != SEQ_IDLE);
    repeat (20) @(posedge clk);
  endtask

  task automatic check_count(input string what, input int got, input int want);
    assert (got == want) else begin
      $display("** Error at %0t: %s = %0d, expected %0d", $time, what, got, want);
      err_cnt++;
    end
  endtask

  task automatic end_test(input string name);
    if (err_cnt == err_base) begin
      $display("test %0d %s: ok", tnum, name);
    end else begin
      $display("test %0d %s: FAILED with %0d errors", tnum, name, err_cnt - err_base);
      fail_cnt++;
    end
    tnum++;
    err_base = err_cnt;
  endtask

  //////////////////////////////////////////////////
  // monitors
  //////////////////////////////////////////////////

  // in order compare of every sample
  always @(posedge clk) begin
    if (rstn && sto_vld) begin
      rx_cnt++;
      assert (exp_q.size() != 0) else begin
        $display("unexpected sample %0d on sto_dat at %0t", sto_dat, $time);
        err_cnt++;
      end
      if (exp_q.size() != 0) begin
        exp_v = exp_q.pop_front();
        assert (sto_dat == exp_v) else begin
          $display("** Error at %0t: sto_dat = %0d, expected %0d", $time, sto_dat, exp_v);
          err_cnt++;
        end
      end
    end
  end

  // credit sink that never returns more than it took
  always @(posedge clk) begin
    if (!rstn) begin
      consumed   = 0;
      returned   = 0;
      sto_credit <= 1'b0;
    end else begin
      if (sto_vld) begin
        assert (consumed < CREDITS + returned) else begin
          $display("sto_vld without a credit held at %0t", $time);
          err_cnt++;
        end
        consumed++;
      end
      if (sto_credit) returned++;  // DUT takes it this edge
      rng_crd = xorshift32(rng_crd);
      if (consumed > returned && (!crd_random || rng_crd[1:0] == 2'b00)) sto_credit <= 1'b1;
      else                                                               sto_credit <= 1'b0;
    end
  end

  // trigger echoes, gap length and idle time
  always @(posedge clk) begin
    if (sto_vld) idle_len = 0;
    else         idle_len++;
    if (trg_out) trg_cnt++;
    if (dut0.seq_state == SEQ_GAP) begin
      gap_len++;
      // queued samples may still drain early in the gap
      assert (!sto_vld || gap_len <= DRAIN_CYC) else begin
        $display("sample emitted deep inside the repetition gap at %0t", $time);
        err_cnt++;
      end
    end else if (gap_len != 0) begin
      check_count("gap length", gap_len, c_rdly);
      gap_cnt++;
      gap_len = 0;
    end
  end

  // watchdog
  always @(posedge clk) begin
    cyc_cnt++;
    if (cyc_cnt > budget) begin
      $display("watchdog expired after %0d cycles, the run did not finish", cyc_cnt);
      $display("Test failures found");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////

  initial begin
    logic [asg_dwo-1:0] rd;
    seq_state_t         st;
    int                 n;
    int                 rx0;
    int                 trg0;
    int                 gap0;
    int                 rx_stop;
    rstn      = 1'b0;
    bus_ena   = 1'b0;
    bus_wen   = 1'b0;
    bus_addr  = '0;
    bus_wdata = '0;
    trg_in    = 1'b0;
    repeat (4) @(posedge clk);
    rstn <= 1'b1;
    @(posedge clk);
    assert (!sto_vld && !trg_out && dut0.seq_state == SEQ_IDLE) else begin
      $display("outputs not idle after reset");
      err_cnt++;
    end

    // random table then full readback
    for (int a = 0; a < (1 << asg_cwm); a++) begin
      rng_stim = xorshift32(rng_stim);
      tbl_ref[a] = rng_stim[asg_dwo-1:0];
      bus_write({1'b1, asg_cwm'(a)}, rng_stim[asg_dwo-1:0]);
    end
    for (int a = 0; a < (1 << asg_cwm); a++) begin
      bus_read({1'b1, asg_cwm'(a)}, rd);
      assert ($signed(rd) == tbl_ref[a]) else begin
        $display("** Error at %0t: bus_rdata[%0d] = %h, expected %h", $time, a, rd, tbl_ref[a]);
        err_cnt++;
      end
    end
    end_test("table write and readback");

    // unit step over one pass gives S+1 samples
    configure(40 << 16, 1 << 16, 0, 1, 0, 0, 1'b0);
    rx0  = rx_cnt;
    trg0 = trg_cnt;
    queue_expected(n);
    fire_trigger();
    wait_done();
    check_count("sample count", rx_cnt - rx0, 41);
    check_count("trg_out pulses", trg_cnt - trg0, 1);
    end_test("single pass without wrap");

    // step of 3.625 keeps the wrap remainder over four passes
    configure((200 << 16) | 'h4000, (3 << 16) | 'ha000, (5 << 16) | 'h2000, 4, 0, 0, 1'b1);
    rx0 = rx_cnt;
    queue_expected(n);
    fire_trigger();
    wait_done();
    check_count("sample count", rx_cnt - rx0, n);
    end_test("fractional step with wrap");

    // two extra runs with gaps and an ignored second trigger
    configure(30 << 16, (2 << 16) | 'h8000, 2 << 16, 2, 2, 40, 1'b0);
    rx0  = rx_cnt;
    trg0 = trg_cnt;
    gap0 = gap_cnt;
    queue_expected(n);
    fire_trigger();
    repeat (4) @(posedge clk);
    fire_trigger();  // sequencer busy
    do read_status(st); while (st != SEQ_GAP);
    wait_done();
    check_count("sample count", rx_cnt - rx0, n);
    check_count("trg_out pulses", trg_cnt - trg0, 1);
    check_count("gaps", gap_cnt - gap0, 2);
    end_test("repetitions with delay");

    // random credit return lets the FIFO fill and adv drop
    crd_random = 1'b1;
    configure(300 << 16, (1 << 16) | 'h3000, 0, 3, 0, 0, 1'b1);
    rx0 = rx_cnt;
    queue_expected(n);
    fire_trigger();
    wait_done();
    crd_random = 1'b0;
    check_count("sample count", rx_cnt - rx0, n);
    end_test("credit back-pressure");

    // abort a long playback and restart from the offset
    configure(120 << 16, 1 << 16, 7 << 16, 50, 0, 0, 1'b0);
    rx0  = rx_cnt;
    trg0 = trg_cnt;
    queue_expected(n);
    fire_trigger();
    while (rx_cnt - rx0 < 20) @(posedge clk);
    bus_write(reg_addr(REG_CTL, 2'd0), asg_dwo'(1));
    rx_stop = rx_cnt;
    while (idle_len < 20) @(posedge clk);  // queued samples drained
    assert (rx_cnt - rx_stop <= DRAIN_CYC) else begin
      $display("** Error at %0t: samples after abort = %0d, expected at most %0d",
               $time, rx_cnt - rx_stop, DRAIN_CYC);
      err_cnt++;
    end
    assert (exp_q.size() != 0) else begin
      $display("playback ran to the end despite the control reset");
      err_cnt++;
    end
    exp_q.delete();
    read_status(st);
    check_count("status", int'(st), int'(SEQ_IDLE));
    reg_write(REG_NCYC, 42'd1);
    c_ncyc = 1;
    queue_expected(n);
    fire_trigger();
    wait_done();
    check_count("trg_out pulses", trg_cnt - trg0, 2);
    end_test("control reset");

    $display("%0d tests, %0d failed, %0d errors", tnum - 1, fail_cnt, err_cnt);
    if (err_cnt == 0) $display("All tests passed!");
    else              $display("Test failures found");
    $finish;
  end

endmodule

`default_nettype wire

// ==== asg_gen.f ====
common/asg_pkg.sv
design/asg_regs.sv
asg/asg_table.sv
asg/asg_sequencer.sv
design/dac_credit_out.sv
design/asg_top.sv
verification/asg_tb.sv

// ==== Makefile ====
# Verilator build and run of the waveform generator testbench

VERILATOR ?= verilator
TOP       ?= asg_tb
FILELIST  ?= asg_gen.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, check $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "All tests passed!" $(LOG); then \
	  echo "PASS"; \
	else \
	  echo "FAIL"; \
	  exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
